//--- len5_params.svh
`ifndef LEN5_PARAMS_SVH_
`define LEN5_PARAMS_SVH_

// ------------------------------
// Architecture
// ------------------------------

// Data and address width
`define LEN5_XLEN 32

// Instruction width in bits
`define LEN5_ILEN 32

// ------------------------------
// Front end
// ------------------------------

// Number of issue queue slots
`define LEN5_IQ_DEPTH 4

// Program counter value after reset
`define LEN5_BOOT_PC 32'h0000_0000

`endif

//--- len5_pkg.sv
`default_nettype none

`include "len5_params.svh"

package len5_pkg;

  // ------------------------------
  // Basic words
  // ------------------------------

  // One integer register value or address
  typedef logic [`LEN5_XLEN-1:0] xlen_t;

  // One uncompressed instruction
  typedef logic [`LEN5_ILEN-1:0] instr_t;

  // ------------------------------
  // Exceptions
  // ------------------------------

  // Low bits of the mcause exception code
  typedef enum logic [3:0] {
    INSTR_MISALIGNED   = 4'd0,
    INSTR_ACCESS_FAULT = 4'd1
  } except_code_t;

  // ------------------------------
  // Major opcodes
  // ------------------------------

  // Conditional branches (B-type)
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  // Jump and link (J-type)
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

endpackage

`default_nettype wire

//--- expipe_pkg.sv
`default_nettype none

package expipe_pkg;

  // ------------------------------
  // Issue queue
  // ------------------------------

  // One slot per fetched instruction
  // 102 bits with 32-bit words
  typedef struct packed {
    // Address the instruction came from
    len5_pkg::xlen_t        curr_pc;
    len5_pkg::instr_t       instruction;
    // Static prediction made at fetch time
    len5_pkg::xlen_t        pred_target;
    logic                   pred_taken;
    // Fetch-side exception info
    logic                   except_raised;
    len5_pkg::except_code_t except_code;
  } iq_entry_t;

endpackage

`default_nettype wire

//--- fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter type DATA_T = logic,
  parameter int  DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  flush_i,
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  // Pointer and occupancy widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ------------------------------
  // Storage and state
  // ------------------------------

  // Payload slots
  DATA_T            mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  // Goes high on the first edge out of reset
  logic             en_q;

  logic             full;
  logic             push;
  logic             pop;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Ready is "not full" only, a pop does not free a slot early
  assign full    = (cnt_q == CNT_W'(DEPTH));
  assign ready_o = en_q & ~full;
  assign valid_o = (cnt_q != '0);

  // Nothing is written in a flush cycle
  assign push = valid_i & ready_o & ~flush_i;
  assign pop  = valid_o & ready_i;

  // Head slot drives the output directly
  assign data_o = mem_q[rd_ptr_q];

  // ------------------------------
  // Pointers and counter
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      en_q     <= 1'b0;
    end else begin
      en_q <= 1'b1;
      if (flush_i) begin
        // Drop every buffered entry
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        // Occupancy only moves when exactly one side fires
        case ({push, pop})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "len5_params.svh"

module fetch_unit (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Redirect from the back end
  input  logic                  flush_i,
  input  len5_pkg::xlen_t       redirect_pc_i,
  // Instruction memory port with same-cycle response
  output len5_pkg::xlen_t       imem_addr_o,
  input  len5_pkg::instr_t      imem_instr_i,
  input  logic                  imem_err_i,
  // Toward the issue queue
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output expipe_pkg::iq_entry_t fetch_entry_o
);

  import len5_pkg::*;

  // ------------------------------
  // Declarations
  // ------------------------------

  // Program counter
  xlen_t      pc_q;
  // Low until the first edge after reset
  logic       run_q;
  // Set after an exception entry leaves
  logic       stall_q;

  // Decode of the returned word
  logic [6:0] opcode;
  xlen_t      imm_b;
  xlen_t      imm_j;
  xlen_t      pc_plus4;
  logic       misaligned;

  // Entry accepted by the queue
  logic       fetch_fire;

  // ------------------------------
  // Memory request and decode
  // ------------------------------

  assign imem_addr_o = pc_q;
  assign pc_plus4    = pc_q + xlen_t'(4);
  assign misaligned  = (pc_q[1:0] != 2'b00);
  assign opcode      = imem_instr_i[6:0];

  // B immediate, bit 0 always zero
  assign imm_b = {{(`LEN5_XLEN-12){imem_instr_i[31]}}, imem_instr_i[7],
                  imem_instr_i[30:25], imem_instr_i[11:8], 1'b0};

  // J immediate
  assign imm_j = {{(`LEN5_XLEN-20){imem_instr_i[31]}}, imem_instr_i[19:12],
                  imem_instr_i[20], imem_instr_i[30:21], 1'b0};

  // ------------------------------
  // Entry and static prediction
  // ------------------------------

  always_comb begin
    fetch_entry_o.curr_pc     = pc_q;
    fetch_entry_o.instruction = imem_instr_i;
    // Default is fall-through
    fetch_entry_o.pred_taken  = 1'b0;
    fetch_entry_o.pred_target = pc_plus4;
    case (opcode)
      OPCODE_BRANCH: begin
        // Negative offset usually closes a loop
        if (imem_instr_i[31]) begin
          fetch_entry_o.pred_taken  = 1'b1;
          fetch_entry_o.pred_target = pc_q + imm_b;
        end
      end
      OPCODE_JAL: begin
        fetch_entry_o.pred_taken  = 1'b1;
        fetch_entry_o.pred_target = pc_q + imm_j;
      end
      default: ;
    endcase

    // Misalignment wins over a bus error
    fetch_entry_o.except_raised = misaligned | imem_err_i;
    fetch_entry_o.except_code   = INSTR_MISALIGNED;
    if (!misaligned && imem_err_i) begin
      fetch_entry_o.except_code = INSTR_ACCESS_FAULT;
    end
  end

  // No entry is offered in a flush cycle
  assign fetch_valid_o = run_q & ~stall_q & ~flush_i;
  assign fetch_fire    = fetch_valid_o & fetch_ready_i;

  // ------------------------------
  // PC and stall state
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q    <= `LEN5_BOOT_PC;
      run_q   <= 1'b0;
      stall_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (flush_i) begin
        pc_q    <= redirect_pc_i;
        stall_q <= 1'b0;
      end else if (fetch_fire) begin
        // Target equals PC + 4 when not taken
        pc_q <= fetch_entry_o.pred_target;
        if (fetch_entry_o.except_raised) begin
          stall_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "len5_params.svh"

module issue_queue (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   flush_i,

  // Handshake and data from fetch
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  expipe_pkg::iq_entry_t  fetch_entry_i,

  // Handshake toward the issue logic
  input  logic                   issue_ready_i,
  output logic                   issue_valid_o,

  // Unpacked head entry
  output len5_pkg::xlen_t        curr_pc_o,
  output len5_pkg::instr_t       instruction_o,
  output len5_pkg::xlen_t        pred_target_o,
  output logic                   pred_taken_o,
  output logic                   except_raised_o,
  output len5_pkg::except_code_t except_code_o
);

  import expipe_pkg::*;

  // Oldest buffered instruction
  iq_entry_t head_entry;

  // ------------------------------
  // Queue storage
  // ------------------------------

  // Fetch entries go in as one packed word
  fifo #(
    .DATA_T(iq_entry_t),
    .DEPTH (`LEN5_IQ_DEPTH)
  ) u_iq_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .flush_i (flush_i),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .data_i  (fetch_entry_i),
    .valid_o (issue_valid_o),
    .ready_i (issue_ready_i),
    .data_o  (head_entry)
  );

  // ------------------------------
  // Issue-side fields
  // ------------------------------

  assign curr_pc_o       = head_entry.curr_pc;
  assign instruction_o   = head_entry.instruction;
  // Prediction travels with the instruction
  assign pred_target_o   = head_entry.pred_target;
  assign pred_taken_o    = head_entry.pred_taken;
  assign except_raised_o = head_entry.except_raised;
  assign except_code_o   = head_entry.except_code;

endmodule

`default_nettype wire

//--- frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  // Back-end redirect
  input  logic                   flush_i,
  input  len5_pkg::xlen_t        redirect_pc_i,

  // Instruction memory
  output len5_pkg::xlen_t        imem_addr_o,
  input  len5_pkg::instr_t       imem_instr_i,
  input  logic                   imem_err_i,

  // Issue interface
  input  logic                   issue_ready_i,
  output logic                   issue_valid_o,
  output len5_pkg::xlen_t        curr_pc_o,
  output len5_pkg::instr_t       instruction_o,
  output len5_pkg::xlen_t        pred_target_o,
  output logic                   pred_taken_o,
  output logic                   except_raised_o,
  output len5_pkg::except_code_t except_code_o
);

  import expipe_pkg::*;

  // ------------------------------
  // Fetch to queue link
  // ------------------------------

  logic      fetch_valid;
  logic      fetch_ready;
  iq_entry_t fetch_entry;

  // PC, prediction and exception marking
  fetch_unit u_fetch_unit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .redirect_pc_i(redirect_pc_i),
    .imem_addr_o  (imem_addr_o),
    .imem_instr_i (imem_instr_i),
    .imem_err_i   (imem_err_i),
    .fetch_valid_o(fetch_valid),
    .fetch_ready_i(fetch_ready),
    .fetch_entry_o(fetch_entry)
  );

  // Buffer between fetch and issue
  issue_queue u_issue_queue (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_ready_o  (fetch_ready),
    .fetch_entry_i  (fetch_entry),
    .issue_ready_i  (issue_ready_i),
    .issue_valid_o  (issue_valid_o),
    .curr_pc_o      (curr_pc_o),
    .instruction_o  (instruction_o),
    .pred_target_o  (pred_target_o),
    .pred_taken_o   (pred_taken_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

endmodule

`default_nettype wire

//--- frontend_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "len5_params.svh"

module frontend_asserts (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  flush_i,
  // Fetch to queue link
  input logic                  fetch_valid_i,
  input logic                  fetch_ready_i,
  input expipe_pkg::iq_entry_t fetch_entry_i,
  // Issue side
  input logic                  issue_valid_i,
  input logic                  issue_ready_i,
  input expipe_pkg::iq_entry_t issue_entry_i
);

  logic push;
  logic pop;
  logic stalled_q;
  // Shadow occupancy of the queue
  int   occ_q;

  assign push = fetch_valid_i & fetch_ready_i & ~flush_i;
  assign pop  = issue_valid_i & issue_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occ_q     <= 0;
      stalled_q <= 1'b0;
    end else if (flush_i) begin
      occ_q     <= 0;
      stalled_q <= 1'b0;
    end else begin
      occ_q <= occ_q + int'(push) - int'(pop);
      // Exception entry accepted by the queue
      if (push && fetch_entry_i.except_raised) begin
        stalled_q <= 1'b1;
      end
    end
  end

  a_idle_after_reset: assert property (@(posedge clk_i) !arst_n_i |=> !issue_valid_i)
    else $error("issue_valid_o high right after reset");

  a_issue_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_valid_i && !issue_ready_i && !flush_i |=> issue_valid_i && $stable(issue_entry_i))
    else $error("Issued entry changed while waiting for issue_ready_i");

  a_stall_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stalled_q |-> !fetch_valid_i)
    else $error("Fetch offered an entry after an exception without a flush");

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> occ_q < `LEN5_IQ_DEPTH)
    else $error("Push into a full issue queue");

endmodule

bind frontend_top frontend_asserts u_frontend_asserts (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .flush_i      (flush_i),
  .fetch_valid_i(fetch_valid),
  .fetch_ready_i(fetch_ready),
  .fetch_entry_i(fetch_entry),
  .issue_valid_i(issue_valid_o),
  .issue_ready_i(issue_ready_i),
  .issue_entry_i({curr_pc_o, instruction_o, pred_target_o, pred_taken_o,
                  except_raised_o, except_code_o})
);

`default_nettype wire

//--- tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "len5_params.svh"

module tb_frontend;

  import len5_pkg::*;
  import expipe_pkg::*;

  localparam logic [31:0] NOP_INSTR        = 32'h0000_0013;
  localparam int          RESET_CYCLES     = 10;
  localparam int          CYCLES_PER_ENTRY = 40;
  // Idle cycles between the end of a stream and the redirect
  localparam int          SETTLE_CYCLES    = 4;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic         clk;
  logic         arst_n;
  logic         flush;
  xlen_t        redirect_pc;
  xlen_t        imem_addr;
  instr_t       imem_instr;
  logic         imem_err;
  logic         issue_ready;
  logic         issue_valid;
  xlen_t        curr_pc;
  instr_t       instruction;
  xlen_t        pred_target;
  logic         pred_taken;
  logic         except_raised;
  except_code_t except_code;

  // ------------------------------
  // Stimulus and model state
  // ------------------------------

  // Program image and bus error addresses
  logic [31:0] image [logic [31:0]];
  bit          fault_addr [logic [31:0]];
  // Redirect commands in file order
  int          cmd_count [$];
  xlen_t       cmd_pc [$];

  xlen_t       model_pc;
  bit          model_stopped;
  int          consumed;
  int          settle;
  bit          done;
  int          seed = 92;
  int          watchdog_cycles;

  // Fetch side of the model
  xlen_t       fetch_pc;
  bit          fetch_stall;
  bit          fetch_run;
  int          q_count;

  frontend_top DUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .flush_i        (flush),
    .redirect_pc_i  (redirect_pc),
    .imem_addr_o    (imem_addr),
    .imem_instr_i   (imem_instr),
    .imem_err_i     (imem_err),
    .issue_ready_i  (issue_ready),
    .issue_valid_o  (issue_valid),
    .curr_pc_o      (curr_pc),
    .instruction_o  (instruction),
    .pred_target_o  (pred_target),
    .pred_taken_o   (pred_taken),
    .except_raised_o(except_raised),
    .except_code_o  (except_code)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // Unlisted words read as NOP
  function automatic instr_t mem_word(xlen_t addr);
    return image.exists(addr) ? image[addr] : NOP_INSTR;
  endfunction

  // Entry that fetch should produce at one PC
  function automatic iq_entry_t expected_entry(xlen_t pc);
    iq_entry_t e;
    instr_t    w;
    int        offset;
    w             = mem_word(pc);
    e.curr_pc     = pc;
    e.instruction = w;
    e.pred_taken  = 1'b0;
    e.pred_target = pc + 32'd4;
    // Backward conditional branch
    if (w[6:0] == 7'b1100011 && w[31]) begin
      offset = int'({w[31], w[7], w[30:25], w[11:8], 1'b0});
      offset = offset - 8192;
      e.pred_taken  = 1'b1;
      e.pred_target = pc + xlen_t'(offset);
    end
    // JAL in either direction
    if (w[6:0] == 7'b1101111) begin
      offset = int'({w[31], w[19:12], w[20], w[30:21], 1'b0});
      if (w[31]) begin
        offset = offset - (1 << 21);
      end
      e.pred_taken  = 1'b1;
      e.pred_target = pc + xlen_t'(offset);
    end
    e.except_raised = 1'b0;
    e.except_code   = INSTR_MISALIGNED;
    if ((pc % 4) != 0) begin
      e.except_raised = 1'b1;
    end else if (fault_addr.exists(pc) != 0) begin
      e.except_raised = 1'b1;
      e.except_code   = INSTR_ACCESS_FAULT;
    end
    return e;
  endfunction

  // Redirect streams plus the final stream up to its exception
  function automatic int count_expected();
    int        total;
    xlen_t     pc;
    iq_entry_t e;
    total = 0;
    pc    = `LEN5_BOOT_PC;
    foreach (cmd_count[i]) begin
      total = total + cmd_count[i];
      pc    = cmd_pc[i];
    end
    for (int k = 0; k < 64; k++) begin
      e     = expected_entry(pc);
      total = total + 1;
      if (e.except_raised) begin
        break;
      end
      pc = e.pred_target;
    end
    return total;
  endfunction

  task automatic load_patterns();
    int          fd;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("frontend_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open frontend_patterns.txt");
      $display("TEST FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      kind = " ";
      void'($fgets(line, fd));
      void'($sscanf(line, "%c", kind));
      case (kind)
        "I": begin
          void'($sscanf(line, "%c %h %h", kind, a, b));
          image[a] = b;
        end
        "A": begin
          void'($sscanf(line, "%c %h", kind, a));
          fault_addr[a] = 1'b1;
        end
        "R": begin
          void'($sscanf(line, "%c %d %h", kind, a, b));
          cmd_count.push_back(int'(a));
          cmd_pc.push_back(b);
        end
        // Comments and blank lines
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error @ %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Compare one issued entry and advance the model
  task automatic check_transfer();
    iq_entry_t e;
    assert (!model_stopped) else begin
      $display("An entry was issued at %0t after an exception, before a redirect", $time);
      $display("TEST FAILED");
      $fatal(1);
    end
    e = expected_entry(model_pc);
    check_field("curr_pc", curr_pc, e.curr_pc);
    check_field("instruction", instruction, e.instruction);
    check_field("pred_taken", 32'(pred_taken), 32'(e.pred_taken));
    check_field("pred_target", pred_target, e.pred_target);
    check_field("except_raised", 32'(except_raised), 32'(e.except_raised));
    if (e.except_raised) begin
      check_field("except_code", 32'(except_code), 32'(e.except_code));
    end
    model_pc      = e.pred_target;
    model_stopped = e.except_raised;
    consumed      = consumed + 1;
  endtask

  // Expected fetch address and queue occupancy for the coming edge
  task automatic track_fetch();
    iq_entry_t e;
    bit        push;
    bit        pop;
    check_field("imem_addr", imem_addr, fetch_pc);
    check_field("issue_valid", 32'(issue_valid), 32'(q_count != 0));
    if (flush) begin
      fetch_pc    = redirect_pc;
      fetch_stall = 1'b0;
      q_count     = 0;
    end else begin
      // Ready is only not full
      push = fetch_run && !fetch_stall && (q_count < `LEN5_IQ_DEPTH);
      pop  = (q_count != 0) && issue_ready;
      if (push) begin
        e           = expected_entry(fetch_pc);
        fetch_pc    = e.pred_target;
        fetch_stall = e.except_raised;
      end
      q_count = q_count + int'(push) - int'(pop);
    end
    fetch_run = 1'b1;
  endtask

  // Runs 1 ns after each rising edge
  task automatic step_stimulus();
    bit stream_done;
    flush       = 1'b0;
    // About 70 % high
    issue_ready = (($unsigned($random(seed)) % 10) < 7);
    stream_done = (cmd_count.size() > 0) ? (consumed == cmd_count[0]) : model_stopped;
    if (stream_done) begin
      // Hold the queue so the redirect has entries to drop
      if (!model_stopped) begin
        issue_ready = 1'b0;
      end
      settle = settle + 1;
      if (settle > SETTLE_CYCLES) begin
        if (cmd_count.size() == 0) begin
          done = 1'b1;
        end else begin
          flush         = 1'b1;
          issue_ready   = 1'b0;
          redirect_pc   = cmd_pc.pop_front();
          void'(cmd_count.pop_front());
          model_pc      = redirect_pc;
          model_stopped = 1'b0;
          consumed      = 0;
          settle        = 0;
        end
      end
    end
    // Same-cycle memory response
    imem_instr = mem_word(imem_addr);
    imem_err   = (fault_addr.exists(imem_addr) != 0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    flush         = 1'b0;
    redirect_pc   = '0;
    imem_instr    = NOP_INSTR;
    imem_err      = 1'b0;
    issue_ready   = 1'b0;
    model_pc      = `LEN5_BOOT_PC;
    model_stopped = 1'b0;
    consumed      = 0;
    settle        = 0;
    done          = 1'b0;
    fetch_pc      = `LEN5_BOOT_PC;
    fetch_stall   = 1'b0;
    fetch_run     = 1'b0;
    q_count       = 0;
    load_patterns();
    watchdog_cycles = RESET_CYCLES + CYCLES_PER_ENTRY * count_expected();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    step_stimulus();
    while (!done) begin
      // Inputs and outputs are settled by the falling edge
      @(negedge clk);
      if (issue_valid && issue_ready && !flush) begin
        check_transfer();
      end
      track_fetch();
      @(posedge clk);
      #1;
      step_stimulus();
    end
    $display("TEST OK");
    $finish;
  end

  // Stalled stream guard
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the issue stream stalled", watchdog_cycles);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- frontend_patterns.txt
# I <addr hex> <instr hex>: program word, A <addr hex>: access fault address
# R <entries dec> <pc hex>: flush to pc after that many entries of the current stream
# Boot stream
I 00000000 00000013
I 00000004 00100093
I 00000008 00200113
# beq x0, x0, +8 is forward, not taken
I 0000000c 00000463
# jal x0, +0x20
I 00000010 0200006f
I 00000030 00300193
# bne x1, x0, -4 loops back to 0x30
I 00000034 fe009ee3
# Straight-line run from 0x100 that hits a bus error at 0x140
I 00000104 00500293
I 00000118 00a00313
I 0000012c 00f00393
A 00000140
# Redirect with a full queue, then one to a misaligned PC
R 12 00000100
R 17 00000202

//--- tb.f
+incdir+.
len5_pkg.sv
expipe_pkg.sv
fifo.sv
fetch_unit.sv
issue_queue.sv
frontend_top.sv
frontend_asserts.sv
tb_frontend.sv

//--- run.sh
#!/bin/sh
# Build the front-end testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_frontend -f tb.f -o tb_frontend_sim \
  && ./obj_dir/tb_frontend_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST OK$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
